// ==== hw/lsu_bus_ctrl.sv ====
`timescale 1ns/10ps

module lsu_bus_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,

   input  lsu_pkg::lsu_req_t    req,
   input  logic                 req_valid,
   output logic                 req_ready,

   input  logic                 hready,
   output lsu_pkg::ahb_addr_t   bus_addr,

   output logic                 addr_accept,
   output lsu_pkg::lsu_dphase_t dphase,
   output logic                 dphase_done
);

   // Data phase state
   typedef enum logic {
      dp_idle    = 1'b0,
      dp_pending = 1'b1
   } dp_state_t;

   dp_state_t            state_q;
   dp_state_t            state_d;
   lsu_pkg::lsu_dphase_t dphase_q;
   lsu_pkg::lsu_dphase_t dphase_d;

   // ==================================================
   // Address phase
   // ==================================================

   // A new address phase is only taken when the bus is ready
   assign req_ready   = hready;
   assign addr_accept = req_valid & hready;

   always_comb begin
      bus_addr.haddr  = req.addr;
      bus_addr.htrans = req_valid ? lsu_pkg::htrans_nonseq : lsu_pkg::htrans_idle;
      bus_addr.hwrite = req.write;
      bus_addr.hsize  = {1'b0, req.size};
   end

   // Fields needed once the address phase is over
   always_comb begin
      dphase_d.write    = req.write;
      dphase_d.size     = req.size;
      dphase_d.sign_ext = req.sign_ext;
      dphase_d.addr_lo  = req.addr[1:0];
      dphase_d.rd       = req.rd;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dphase_q <= '0;
      end else if (addr_accept) begin
         dphase_q <= dphase_d;
      end
   end

   // ==================================================
   // Data phase state machine
   // ==================================================

   // Moves only on hready, so a stalled phase holds its state
   always_comb begin
      state_d = state_q;
      if (hready) begin
         if (req_valid) begin
            state_d = dp_pending;
         end else begin
            state_d = dp_idle;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= dp_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // Pending data phase completes in this cycle
   assign dphase_done = (state_q == dp_pending) & hready;
   assign dphase      = dphase_q;

endmodule

// ==== hw/lsu_load_extract.sv ====
`timescale 1ns/10ps

module lsu_load_extract (
   input  lsu_pkg::lsu_dphase_t        dphase,
   input  logic                        dphase_done,
   input  logic [lsu_pkg::data_w-1:0]  hrdata,
   output lsu_pkg::lsu_wb_t            wb,
   output logic                        wb_valid
);

   logic [7:0]  byte_lane;
   logic [15:0] half_lane;
   logic        fill;

   // ==================================================
   // Lane select
   // ==================================================

   always_comb begin
      case (dphase.addr_lo)
         2'b00:   byte_lane = hrdata[7:0];
         2'b01:   byte_lane = hrdata[15:8];
         2'b10:   byte_lane = hrdata[23:16];
         default: byte_lane = hrdata[31:24];
      endcase
      half_lane = dphase.addr_lo[1] ? hrdata[31:16] : hrdata[15:0];
   end

   // ==================================================
   // Extension and write-back
   // ==================================================

   always_comb begin
      fill    = 1'b0;
      wb.rd   = dphase.rd;
      case (dphase.size)
         lsu_pkg::size_byte: begin
            fill    = dphase.sign_ext & byte_lane[7];
            wb.data = {{24{fill}}, byte_lane};
         end
         lsu_pkg::size_half: begin
            fill    = dphase.sign_ext & half_lane[15];
            wb.data = {{16{fill}}, half_lane};
         end
         default: begin
            wb.data = hrdata;
         end
      endcase
   end

   // Stores end their data phase without a write-back
   assign wb_valid = dphase_done & ~dphase.write;

endmodule

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

   // ==================================================
   // Widths
   // ==================================================

   // Data bus and address width
   localparam int data_w = 32;

   // Destination register index width
   localparam int reg_idx_w = 5;

   // ==================================================
   // Bus encodings
   // ==================================================

   // AHB-Lite transfer types used by this master
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // Access size, same codes as the low bits of hsize
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } lsu_size_t;

   // ==================================================
   // Packed structs
   // ==================================================

   // Core-side load or store request
   typedef struct packed {
      logic                 write;
      lsu_size_t            size;
      logic                 sign_ext;
      logic [data_w-1:0]    addr;
      logic [data_w-1:0]    wdata;
      logic [reg_idx_w-1:0] rd;
   } lsu_req_t;

   // Captured at the end of the address phase
   typedef struct packed {
      logic                 write;
      lsu_size_t            size;
      logic                 sign_ext;
      logic [1:0]           addr_lo;
      logic [reg_idx_w-1:0] rd;
   } lsu_dphase_t;

   // Load result towards the register file
   typedef struct packed {
      logic [reg_idx_w-1:0] rd;
      logic [data_w-1:0]    data;
   } lsu_wb_t;

   // Address-phase outputs of the master
   typedef struct packed {
      logic [data_w-1:0] haddr;
      logic [1:0]        htrans;
      logic              hwrite;
      logic [2:0]        hsize;
   } ahb_addr_t;

endpackage

// ==== hw/lsu_store_align.sv ====
`timescale 1ns/10ps

module lsu_store_align (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_req_t           req,
   input  logic                        addr_accept,
   output logic [lsu_pkg::data_w-1:0]  hwdata
);

   logic [lsu_pkg::data_w-1:0] lane_data;
   logic [lsu_pkg::data_w-1:0] hwdata_q;

   // ==================================================
   // Byte lane placement
   // ==================================================

   always_comb begin
      lane_data = '0;
      case (req.size)
         lsu_pkg::size_byte: begin
            case (req.addr[1:0])
               2'b00:   lane_data[7:0]   = req.wdata[7:0];
               2'b01:   lane_data[15:8]  = req.wdata[7:0];
               2'b10:   lane_data[23:16] = req.wdata[7:0];
               default: lane_data[31:24] = req.wdata[7:0];
            endcase
         end
         lsu_pkg::size_half: begin
            // Only bit 1 matters for an aligned halfword
            if (req.addr[1]) begin
               lane_data[31:16] = req.wdata[15:0];
            end else begin
               lane_data[15:0] = req.wdata[15:0];
            end
         end
         default: begin
            lane_data = req.wdata;
         end
      endcase
   end

   // Held for the whole data phase, including wait states
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdata_q <= '0;
      end else if (addr_accept) begin
         hwdata_q <= lane_data;
      end
   end

   assign hwdata = hwdata_q;

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top (
   input  logic                        clk,
   input  logic                        rst_n,

   // Core request side
   input  lsu_pkg::lsu_req_t           req,
   input  logic                        req_valid,
   output logic                        req_ready,

   // AHB-Lite data bus
   output lsu_pkg::ahb_addr_t          bus_addr,
   output logic [lsu_pkg::data_w-1:0]  hwdata,
   input  logic [lsu_pkg::data_w-1:0]  hrdata,
   input  logic                        hready,

   // Load write-back
   output lsu_pkg::lsu_wb_t            wb,
   output logic                        wb_valid
);

   // ==================================================
   // Internal connections
   // ==================================================

   lsu_pkg::lsu_dphase_t dphase;
   logic                 dphase_done;
   logic                 addr_accept;

   // Address phase and data-phase tracking
   lsu_bus_ctrl u_bus_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .hready      (hready),
      .bus_addr    (bus_addr),
      .addr_accept (addr_accept),
      .dphase      (dphase),
      .dphase_done (dphase_done)
   );

   // Store data onto byte lanes
   lsu_store_align u_store_align (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .addr_accept (addr_accept),
      .hwdata      (hwdata)
   );

   // Load lane select and extension
   lsu_load_extract u_load_extract (
      .dphase      (dphase),
      .dphase_done (dphase_done),
      .hrdata      (hrdata),
      .wb          (wb),
      .wb_valid    (wb_valid)
   );

endmodule

// ==== lsu_top.f ====
hw/lsu_pkg.sv
hw/lsu_bus_ctrl.sv
hw/lsu_store_align.sv
hw/lsu_load_extract.sv
hw/lsu_top.sv
verification/lsu_clock_gen.sv
verification/lsu_asserts.sv
verification/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator.
# Exits non-zero when the build fails, the simulation fails,
# or the log reports failed checks.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
EXE=lsu_sim

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module lsu_tb \
   --Mdir "$BUILD_DIR" \
   -o "$EXE" \
   -f lsu_top.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== verification/lsu_asserts.sv ====
`timescale 1ns/10ps

module lsu_asserts (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 req_valid,
   input logic                 hready,
   input lsu_pkg::ahb_addr_t   bus_addr,
   input lsu_pkg::lsu_dphase_t dphase
);

   // ==================================================
   // AHB-Lite master rules
   // ==================================================

   // Address phase must hold while the slave inserts wait states
   addr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      (!hready && bus_addr.htrans == lsu_pkg::htrans_nonseq) |=> $stable(bus_addr))
      else $error("address phase changed during a wait state");

   // No transfer without a request
   idle_a: assert property (@(posedge clk) disable iff (!rst_n)
      !req_valid |-> bus_addr.htrans == lsu_pkg::htrans_idle)
      else $error("htrans not idle while req_valid is low");

   // Captured data-phase fields stay put during a stall
   dphase_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      !hready |=> $stable(dphase))
      else $error("pending data phase changed while hready was low");

endmodule

bind lsu_bus_ctrl lsu_asserts u_asserts (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .hready    (hready),
   .bus_addr  (bus_addr),
   .dphase    (dphase)
);

// ==== verification/lsu_clock_gen.sv ====
`timescale 1ns/10ps

module lsu_clock_gen (
   output logic clk,
   output logic rst_n
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset held for 16 cycles, released away from the rising edge
   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// ==== verification/lsu_tb.sv ====
`timescale 1ns/10ps

module lsu_tb;

   localparam int max_wait = 3;

   logic                       clk;
   logic                       rst_n;
   lsu_pkg::lsu_req_t          req;
   logic                       req_valid;
   logic                       req_ready;
   lsu_pkg::ahb_addr_t         bus_addr;
   logic [lsu_pkg::data_w-1:0] hwdata;
   logic [lsu_pkg::data_w-1:0] hrdata;
   logic                       hready;
   lsu_pkg::lsu_wb_t           wb;
   logic                       wb_valid;

   // Stimulus table
   string             names[$];
   lsu_pkg::lsu_req_t reqs[$];
   logic [31:0]       exps[$];

   // Slave memory and data-phase state
   logic [7:0]  mem [0:63];
   logic        dp_active;
   logic        dp_write;
   logic [2:0]  dp_size;
   logic [5:0]  dp_addr;
   int          wait_left;
   logic        random_waits;
   logic [31:0] lfsr_q;

   int inflight[$];
   int next;
   int tests_run;
   int tests_failed;
   int other_errors;
   int wb_seen;
   int wb_expected;
   int cycles = 0;
   int cycle_limit = 100000;

   lsu_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

   lsu_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .bus_addr  (bus_addr),
      .hwdata    (hwdata),
      .hrdata    (hrdata),
      .hready    (hready),
      .wb        (wb),
      .wb_valid  (wb_valid)
   );

   // ==================================================
   // Helpers
   // ==================================================

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   // One LFSR step per bit
   function automatic int draw_bits(input int bits);
      int v;
      v = 0;
      for (int i = 0; i < bits; i++) begin
         v = v * 2;
         if (lfsr_q[0]) v = v + 1;
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   task automatic add_entry(input string name, input logic write,
                            input lsu_pkg::lsu_size_t size, input logic sign_ext,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [4:0] rd, input logic [31:0] expected);
      lsu_pkg::lsu_req_t r;
      r.write    = write;
      r.size     = size;
      r.sign_ext = sign_ext;
      r.addr     = addr;
      r.wdata    = wdata;
      r.rd       = rd;
      names.push_back(name);
      reqs.push_back(r);
      exps.push_back(expected);
   endtask

   function automatic logic [31:0] read_word(input logic [5:0] a);
      logic [5:0] base;
      base = {a[5:2], 2'b00};
      return {mem[base + 6'd3], mem[base + 6'd2], mem[base + 6'd1], mem[base]};
   endfunction

   // Writes only the lanes selected by hsize and the low address bits
   task automatic store_lanes(input logic [5:0] a, input logic [2:0] size,
                              input logic [31:0] data);
      logic [5:0] ba;
      logic       en;
      for (int b = 0; b < 4; b++) begin
         ba = {a[5:2], 2'(b)};
         en = (size == 3'd2) || (size == 3'd1 && ba[1] == a[1]) ||
              (size == 3'd0 && ba[1:0] == a[1:0]);
         if (en) mem[ba] = data[8*b +: 8];
      end
   endtask

   task automatic finish_test(input int k);
      logic bad;
      bad = 1'b0;
      tests_run++;
      if (reqs[k].write) begin
         assert (!wb_valid) else begin
            $display("stray write-back during store %s", names[k]);
            bad = 1'b1;
         end
      end else begin
         assert (wb_valid) else begin
            $display("no write-back for load %s", names[k]);
            bad = 1'b1;
         end
         if (wb_valid) begin
            wb_seen++;
            assert (wb.rd == reqs[k].rd && wb.data == exps[k]) else begin
               $display("FAIL %s expected rd %0d data %h actual rd %0d data %h",
                        names[k], reqs[k].rd, exps[k], wb.rd, wb.data);
               bad = 1'b1;
            end
         end
      end
      if (bad) tests_failed++;
      else $display("PASS %s", names[k]);
   endtask

   // ==================================================
   // Slave model, sampled mid-cycle
   // ==================================================

   task automatic observe_cycle();
      int k;
      // Back-pressure from the slave reaches the core as req_ready
      assert (req_ready == hready) else begin
         $display("req_ready does not follow the slave hready");
         other_errors++;
      end
      if (dp_active && hready) begin
         k = inflight.pop_front();
         finish_test(k);
         if (dp_write) store_lanes(dp_addr, dp_size, hwdata);
      end else begin
         assert (!wb_valid) else begin
            $display("write-back seen while no load was finishing");
            other_errors++;
         end
      end
      if (hready) begin
         if (bus_addr.htrans == lsu_pkg::htrans_nonseq) begin
            dp_active = 1'b1;
            dp_write  = bus_addr.hwrite;
            dp_size   = bus_addr.hsize;
            dp_addr   = bus_addr.haddr[5:0];
            wait_left = random_waits ? draw_bits(2) : 0;
            inflight.push_back(next);
            next++;
         end else begin
            dp_active = 1'b0;
         end
      end else if (wait_left > 0) begin
         wait_left--;
      end
   endtask

   task automatic drive_next();
      hready = !(dp_active && wait_left != 0);
      hrdata = dp_active ? read_word(dp_addr) : 32'h0;
      if (next < reqs.size()) begin
         req       = reqs[next];
         req_valid = 1'b1;
      end else begin
         req_valid = 1'b0;
      end
   endtask

   // Drive on the falling edge, look before the next rising edge
   task automatic run_cycle();
      @(negedge clk);
      drive_next();
      #1;
      observe_cycle();
   endtask

   // ==================================================
   // Run limit
   // ==================================================

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, transfers did not complete", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // ==================================================
   // Main sequence
   // ==================================================

   initial begin
      req          = '0;
      req_valid    = 1'b0;
      hready       = 1'b1;
      hrdata       = 32'h0;
      dp_active    = 1'b0;
      dp_write     = 1'b0;
      dp_size      = 3'd0;
      dp_addr      = 6'd0;
      wait_left    = 0;
      random_waits = 1'b0;
      lfsr_q       = 32'h9f01_5983;
      next         = 0;
      tests_run    = 0;
      tests_failed = 0;
      other_errors = 0;
      wb_seen      = 0;
      for (int i = 0; i < 64; i++) mem[6'(i)] = 8'(i * 5 + 3) ^ 8'h3c;

      add_entry("st_w",      1'b1, lsu_pkg::size_word, 1'b0, 32'h1000_0010, 32'hdead_beef, 5'd0,  32'h0);
      add_entry("ld_w",      1'b0, lsu_pkg::size_word, 1'b0, 32'h1000_0010, 32'h0, 5'd5,  32'hdead_beef);
      add_entry("st_b0",     1'b1, lsu_pkg::size_byte, 1'b0, 32'h1000_0020, 32'h1234_5681, 5'd0, 32'h0);
      add_entry("st_b1",     1'b1, lsu_pkg::size_byte, 1'b0, 32'h1000_0021, 32'hffff_ff7f, 5'd0, 32'h0);
      add_entry("st_b2",     1'b1, lsu_pkg::size_byte, 1'b0, 32'h1000_0022, 32'h0000_00c3, 5'd0, 32'h0);
      add_entry("st_b3",     1'b1, lsu_pkg::size_byte, 1'b0, 32'h1000_0023, 32'haaaa_aa05, 5'd0, 32'h0);
      add_entry("ld_b0_s",   1'b0, lsu_pkg::size_byte, 1'b1, 32'h1000_0020, 32'h0, 5'd1,  32'hffff_ff81);
      add_entry("ld_b0_u",   1'b0, lsu_pkg::size_byte, 1'b0, 32'h1000_0020, 32'h0, 5'd2,  32'h0000_0081);
      add_entry("ld_b1_s",   1'b0, lsu_pkg::size_byte, 1'b1, 32'h1000_0021, 32'h0, 5'd3,  32'h0000_007f);
      add_entry("ld_b2_s",   1'b0, lsu_pkg::size_byte, 1'b1, 32'h1000_0022, 32'h0, 5'd4,  32'hffff_ffc3);
      add_entry("ld_b2_u",   1'b0, lsu_pkg::size_byte, 1'b0, 32'h1000_0022, 32'h0, 5'd6,  32'h0000_00c3);
      add_entry("ld_b3_s",   1'b0, lsu_pkg::size_byte, 1'b1, 32'h1000_0023, 32'h0, 5'd7,  32'h0000_0005);
      add_entry("ld_bw",     1'b0, lsu_pkg::size_word, 1'b0, 32'h1000_0020, 32'h0, 5'd8,  32'h05c3_7f81);
      add_entry("st_h_init", 1'b1, lsu_pkg::size_word, 1'b0, 32'h1000_0030, 32'h1122_3344, 5'd0, 32'h0);
      add_entry("st_h0",     1'b1, lsu_pkg::size_half, 1'b0, 32'h1000_0030, 32'habcd_8001, 5'd0, 32'h0);
      add_entry("ld_h0_s",   1'b0, lsu_pkg::size_half, 1'b1, 32'h1000_0030, 32'h0, 5'd9,  32'hffff_8001);
      add_entry("ld_h0_u",   1'b0, lsu_pkg::size_half, 1'b0, 32'h1000_0030, 32'h0, 5'd10, 32'h0000_8001);
      add_entry("ld_hw_a",   1'b0, lsu_pkg::size_word, 1'b0, 32'h1000_0030, 32'h0, 5'd11, 32'h1122_8001);
      add_entry("st_h1",     1'b1, lsu_pkg::size_half, 1'b0, 32'h1000_0032, 32'h0000_f00d, 5'd0, 32'h0);
      add_entry("ld_h1_s",   1'b0, lsu_pkg::size_half, 1'b1, 32'h1000_0032, 32'h0, 5'd12, 32'hffff_f00d);
      add_entry("ld_h1_u",   1'b0, lsu_pkg::size_half, 1'b0, 32'h1000_0032, 32'h0, 5'd13, 32'h0000_f00d);
      add_entry("ld_hw_b",   1'b0, lsu_pkg::size_word, 1'b0, 32'h1000_0030, 32'h0, 5'd14, 32'hf00d_8001);
      add_entry("st_b_mid",  1'b1, lsu_pkg::size_byte, 1'b0, 32'h1000_0011, 32'h0000_0000, 5'd0, 32'h0);
      add_entry("ld_w_mid",  1'b0, lsu_pkg::size_word, 1'b0, 32'h1000_0010, 32'h0, 5'd31, 32'hdead_00ef);

      wb_expected = 0;
      foreach (reqs[i]) if (!reqs[i].write) wb_expected += 2;
      cycle_limit = 16 + 8 + 2 * reqs.size() * (max_wait + 2) + 40;

      @(posedge rst_n);
      repeat (3) begin
         @(negedge clk);
         assert (bus_addr.htrans == lsu_pkg::htrans_idle && !wb_valid) else begin
            $display("bus not idle after reset");
            other_errors++;
         end
      end

      // First pass back to back, second pass with random wait states
      for (int pass = 0; pass < 2; pass++) begin
         random_waits = (pass == 1);
         next = 0;
         while (next < reqs.size() || inflight.size() != 0) begin
            run_cycle();
         end
      end

      // Drain, catching late write-backs
      repeat (4) begin
         run_cycle();
      end

      assert (wb_seen == wb_expected) else begin
         $display("write-back count wrong, saw %0d of %0d", wb_seen, wb_expected);
         other_errors++;
      end

      $display("tests %0d, failed %0d, other errors %0d",
               tests_run, tests_failed, other_errors);
      if (tests_failed == 0 && other_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
